// ==== verif/dmmu_tests.txt ====
# W sel idx data : TLB write, sel 0 = tag/valid half, sel 1 = ppn/attribute half, hex
# L vpn we root mmu_en ppn miss fault uncached : lookup and expected result, hex
W 0 1 00011001
W 1 1 2A001079
W 0 2 00102001
W 1 2 80002079
W 0 3 00033001
W 1 3 003030F9
W 0 4 00044001
W 1 4 00404041
W 0 8 00088000
W 1 8 00808079
# Translation off, identity mapping
L 00011 0 0 0 00011 0 0 0
L 00088 1 0 0 00088 0 0 0
L 80001 0 1 0 80001 0 0 1
L 00003 0 1 0 00003 0 0 1
# Hits with every right granted, segment and UNC bit
L 00011 0 1 1 2A001 0 0 0
L 00011 1 1 1 2A001 0 0 0
L 00011 0 0 1 2A001 0 0 0
L 00011 1 0 1 2A001 0 0 0
L 00102 0 0 1 80002 0 0 1
L 00033 1 1 1 00303 0 0 1
# Misses, wrong tag and cleared valid bit
L 00021 0 1 1 2A001 1 0 0
L 00088 0 1 1 00808 1 0 0
L 00174 1 0 1 00404 1 0 0
# Root read only entry
L 00044 0 1 1 00404 0 0 0
L 00044 1 1 1 00404 0 1 0
L 00044 0 0 1 00404 0 1 0
L 00044 1 0 1 00404 0 1 0
# Rewrites through the handshake
W 1 4 00404079
L 00044 1 0 1 00404 0 0 0
W 0 1 00021001
L 00021 0 1 1 2A001 0 0 0
L 00011 0 1 1 2A001 1 0 0
W 0 8 00088001
L 00088 0 1 1 00808 0 0 0

// ==== list.f ====
design/dmmu_pkg.sv
design/tlb_sdpram.sv
design/dmmu.sv
design/tlb_write_ctrl.sv
design/dmmu_top.sv
verif/dmmu_sva.sv
verif/dmmu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = dmmu_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/dmmu_tb.sv ====
// Testbench for the data MMU top level
// Replays verif/dmmu_tests.txt line by line
// W lines fill the TLB through the req/ack port, L lines run one lookup and check it

`timescale 1ns/1ps

module dmmu_tb import dmmu_pkg::*; ();

   localparam int PAGE_SIZE_LOG2 = 12;
   localparam int TLB_SETS_LOG2  = 4;
   localparam int VPN_W          = ADDR_W - PAGE_SIZE_LOG2;
   // Cycles allowed for each handshake edge
   localparam int TIMEOUT        = 20;

   logic                     clk;
   logic                     arst_n;
   logic                     re;
   logic [VPN_W-1:0]         vpn;
   logic                     we;
   logic                     mode_root;
   logic                     mmu_en;
   logic [VPN_W-1:0]         ppn;
   logic                     tlb_miss_exc;
   logic                     page_fault_exc;
   logic                     uncached;
   logic                     wr_req;
   logic                     wr_sel;
   logic [TLB_SETS_LOG2-1:0] wr_idx;
   word_t                    wr_data;
   logic                     wr_ack;

   // Default parameters, names match the top level ports
   dmmu_top dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_with_fail();
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic give_up(input string why);
      $display("ERROR: %s", why);
      stop_with_fail();
   endtask

   task automatic check_page(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_with_fail();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
         stop_with_fail();
      end
   endtask

   // Drive point, 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_ack(input logic level, input string what);
      int cycles;
      cycles = 0;
      while (wr_ack !== level) begin
         if (cycles == TIMEOUT) begin
            give_up($sformatf("wr_ack did not %s within %0d cycles", what, TIMEOUT));
         end
         next_cycle();
         cycles++;
      end
   endtask

   // One full four-phase write
   task automatic do_write(input logic sel, input logic [TLB_SETS_LOG2-1:0] idx,
                           input word_t data);
      next_cycle();
      wr_sel  = sel;
      wr_idx  = idx;
      wr_data = data;
      wr_req  = 1'b1;
      wait_ack(1'b1, "rise");
      // Release, ack must follow
      wr_req = 1'b0;
      wait_ack(1'b0, "fall");
   endtask

   // One-cycle re, result checked on the next cycle
   task automatic do_lookup(input logic [VPN_W-1:0] v, input logic w, input logic root,
                            input logic en, input logic [VPN_W-1:0] exp_ppn,
                            input logic exp_miss, input logic exp_fault, input logic exp_unc);
      next_cycle();
      re        = 1'b1;
      vpn       = v;
      we        = w;
      mode_root = root;
      mmu_en    = en;
      next_cycle();
      re = 1'b0;
      check_page("ppn", word_t'(ppn), word_t'(exp_ppn));
      check_flag("tlb_miss_exc", tlb_miss_exc, exp_miss);
      check_flag("page_fault_exc", page_fault_exc, exp_fault);
      check_flag("uncached", uncached, exp_unc);
   endtask

   initial begin
      int          fd;
      int          n;
      int          n_writes;
      int          n_lookups;
      string       line;
      logic [31:0] c_sel, c_idx, c_data;
      logic [31:0] c_vpn, c_we, c_root, c_en, c_ppn, c_miss, c_fault, c_unc;
      n_writes  = 0;
      n_lookups = 0;
      arst_n    = 1'b0;
      re        = 1'b0;
      vpn       = '0;
      we        = 1'b0;
      mode_root = 1'b0;
      mmu_en    = 1'b0;
      wr_req    = 1'b0;
      wr_sel    = 1'b0;
      wr_idx    = '0;
      wr_data   = '0;
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      // Quiet outputs before the first lookup
      next_cycle();
      check_flag("tlb_miss_exc after reset", tlb_miss_exc, 1'b0);
      check_flag("page_fault_exc after reset", page_fault_exc, 1'b0);
      check_flag("uncached after reset", uncached, 1'b0);
      check_flag("wr_ack after reset", wr_ack, 1'b0);

      fd = $fopen("verif/dmmu_tests.txt", "r");
      if (fd == 0) begin
         give_up("could not open verif/dmmu_tests.txt");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") begin
            // Blank or comment line
         end else if (line.getc(0) == "W") begin
            n = $sscanf(line, "W %h %h %h", c_sel, c_idx, c_data);
            if (n != 3) begin
               give_up({"malformed write line: ", line});
            end
            do_write(c_sel[0], c_idx[TLB_SETS_LOG2-1:0], c_data);
            n_writes++;
         end else if (line.getc(0) == "L") begin
            n = $sscanf(line, "L %h %h %h %h %h %h %h %h", c_vpn, c_we, c_root, c_en,
                        c_ppn, c_miss, c_fault, c_unc);
            if (n != 8) begin
               give_up({"malformed lookup line: ", line});
            end
            do_lookup(c_vpn[VPN_W-1:0], c_we[0], c_root[0], c_en[0], c_ppn[VPN_W-1:0],
                      c_miss[0], c_fault[0], c_unc[0]);
            n_lookups++;
         end else begin
            give_up({"unknown command in test file: ", line});
         end
      end
      $fclose(fd);

      if (n_lookups == 0) begin
         give_up("the test file held no lookups");
      end else begin
         $display("Ran %0d writes and %0d lookups", n_writes, n_lookups);
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

// ==== verif/dmmu_sva.sv ====
// Assertions on the TLB write handshake and the exception outputs
// Bound into dmmu_top, reaches the internal write enables by name

`timescale 1ns/1ps

module dmmu_sva (
   input logic clk,
   input logic arst_n,
   input logic tlb_miss_exc,
   input logic page_fault_exc,
   input logic lo_we,
   input logic hi_we,
   input logic wr_req,
   input logic wr_ack
);

   // A miss hides any page fault
   a_exc_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(tlb_miss_exc && page_fault_exc))
      else $error("tlb_miss_exc and page_fault_exc high together");

   // Only one RAM half written per handshake
   a_we_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(lo_we && hi_we))
      else $error("lo_we and hi_we high together");

   a_we_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      (lo_we || hi_we) |=> !(lo_we || hi_we))
      else $error("TLB write enable longer than one cycle");

   // Four-phase release order
   a_ack_release: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(wr_ack) |-> $past(!wr_req))
      else $error("wr_ack dropped while wr_req was still high");

endmodule

bind dmmu_top dmmu_sva u_sva (
   .clk            (clk),
   .arst_n         (arst_n),
   .tlb_miss_exc   (tlb_miss_exc),
   .page_fault_exc (page_fault_exc),
   .lo_we          (lo_we),
   .hi_we          (hi_we),
   .wr_req         (wr_req),
   .wr_ack         (wr_ack)
);

// ==== design/dmmu_top.sv ====
// Data MMU top level
// Joins the lookup stage, the two TLB RAM halves and the write controller
// Parameters set here are passed down to every block

`timescale 1ns/1ps

module dmmu_top import dmmu_pkg::*; #(
   parameter int PAGE_SIZE_LOG2  = 12,
   parameter int TLB_SETS_LOG2   = 4,
   parameter int UNCACHED_SEG_EN = 1
) (
   input  logic                             clk,
   input  logic                             arst_n,
   // Lookup from the load/store unit
   input  logic                             re,
   input  logic [ADDR_W-PAGE_SIZE_LOG2-1:0] vpn,
   input  logic                             we,
   input  logic                             mode_root,
   input  logic                             mmu_en,
   output logic [ADDR_W-PAGE_SIZE_LOG2-1:0] ppn,
   output logic                             tlb_miss_exc,
   output logic                             page_fault_exc,
   output logic                             uncached,
   // TLB fill handshake
   input  logic                             wr_req,
   input  logic                             wr_sel,
   input  logic [TLB_SETS_LOG2-1:0]         wr_idx,
   input  word_t                            wr_data,
   output logic                             wr_ack
);

   logic [TLB_SETS_LOG2-1:0] tlb_raddr;
   word_t                    tlb_lo;
   word_t                    tlb_hi;
   logic                     lo_we;
   logic                     hi_we;
   logic [TLB_SETS_LOG2-1:0] ram_waddr;
   word_t                    ram_wdata;

   tlb_write_ctrl #(
      .TLB_SETS_LOG2 (TLB_SETS_LOG2)
   ) u_wr_ctrl (
      .clk       (clk),
      .arst_n    (arst_n),
      .wr_req    (wr_req),
      .wr_sel    (wr_sel),
      .wr_idx    (wr_idx),
      .wr_data   (wr_data),
      .wr_ack    (wr_ack),
      .lo_we     (lo_we),
      .hi_we     (hi_we),
      .ram_waddr (ram_waddr),
      .ram_wdata (ram_wdata)
   );

   // Tag and valid half
   tlb_sdpram #(
      .AW        (TLB_SETS_LOG2),
      .DW        (DATA_W),
      .BYPASS_EN (1)
   ) tlb_lo_ram (
      .clk    (clk),
      .arst_n (arst_n),
      .raddr  (tlb_raddr),
      .re     (re),
      .waddr  (ram_waddr),
      .we     (lo_we),
      .din    (ram_wdata),
      .dout   (tlb_lo)
   );

   // Page number and attribute half
   tlb_sdpram #(
      .AW        (TLB_SETS_LOG2),
      .DW        (DATA_W),
      .BYPASS_EN (1)
   ) tlb_hi_ram (
      .clk    (clk),
      .arst_n (arst_n),
      .raddr  (tlb_raddr),
      .re     (re),
      .waddr  (ram_waddr),
      .we     (hi_we),
      .din    (ram_wdata),
      .dout   (tlb_hi)
   );

   dmmu #(
      .PAGE_SIZE_LOG2  (PAGE_SIZE_LOG2),
      .TLB_SETS_LOG2   (TLB_SETS_LOG2),
      .UNCACHED_SEG_EN (UNCACHED_SEG_EN)
   ) u_dmmu (
      .clk            (clk),
      .arst_n         (arst_n),
      .re             (re),
      .vpn            (vpn),
      .we             (we),
      .mode_root      (mode_root),
      .mmu_en         (mmu_en),
      .tlb_lo         (tlb_lo),
      .tlb_hi         (tlb_hi),
      .tlb_raddr      (tlb_raddr),
      .ppn            (ppn),
      .tlb_miss_exc   (tlb_miss_exc),
      .page_fault_exc (page_fault_exc),
      .uncached       (uncached)
   );

endmodule

// ==== design/tlb_write_ctrl.sv ====
// TLB write port controller
// Four-phase req/ack slave, one handshake writes one half of one entry
// Pulses the selected RAM write enable once, then holds ack until req drops

`timescale 1ns/1ps

module tlb_write_ctrl import dmmu_pkg::*; #(
   parameter int TLB_SETS_LOG2 = 4
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     wr_req,
   input  logic                     wr_sel,
   input  logic [TLB_SETS_LOG2-1:0] wr_idx,
   input  word_t                    wr_data,
   output logic                     wr_ack,
   output logic                     lo_we,
   output logic                     hi_we,
   output logic [TLB_SETS_LOG2-1:0] ram_waddr,
   output word_t                    ram_wdata
);

   tlb_wr_state_e state;
   tlb_wr_state_e state_nxt;

   // Request held for the write cycle
   logic sel_r;

   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (wr_req) state_nxt = WRITE;
         // Single write cycle
         WRITE:   state_nxt = ACK;
         // Wait for the requester to release
         ACK:     if (!wr_req) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Latch on the way into WRITE
   // Late changes on the bus cannot reach the RAM
   always_ff @(posedge clk) begin
      if (state == IDLE && wr_req) begin
         sel_r     <= wr_sel;
         ram_waddr <= wr_idx;
         ram_wdata <= wr_data;
      end
   end

   // One enable, one cycle
   assign lo_we = (state == WRITE) && !sel_r;
   assign hi_we = (state == WRITE) && sel_r;

   // Moore output, straight from the state register
   assign wr_ack = (state == ACK);

endmodule

// ==== design/dmmu.sv ====
// Data MMU lookup stage
// Indexes the TLB RAMs with the low vpn bits on re, captures the request,
// then compares the tag, checks permissions and forms the result one cycle later
// The two TLB RAMs sit next to this module in the top level

`timescale 1ns/1ps

module dmmu import dmmu_pkg::*; #(
   parameter int PAGE_SIZE_LOG2  = 12,
   parameter int TLB_SETS_LOG2   = 4,
   parameter int UNCACHED_SEG_EN = 1
) (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic                             re,
   input  logic [ADDR_W-PAGE_SIZE_LOG2-1:0] vpn,
   input  logic                             we,
   input  logic                             mode_root,
   input  logic                             mmu_en,
   input  word_t                            tlb_lo,
   input  word_t                            tlb_hi,
   output logic [TLB_SETS_LOG2-1:0]         tlb_raddr,
   output logic [ADDR_W-PAGE_SIZE_LOG2-1:0] ppn,
   output logic                             tlb_miss_exc,
   output logic                             page_fault_exc,
   output logic                             uncached
);

   // Page number width, same for virtual and physical
   localparam int VPN_W = ADDR_W - PAGE_SIZE_LOG2;

   // Captured request
   logic [VPN_W-1:0] vpn_r;
   logic             we_r;
   logic             root_r;
   logic             mmu_en_r;

   // Entry fields
   logic             tlb_v;
   logic [VPN_W-1:0] tlb_tag;
   logic             tlb_uw;
   logic             tlb_ur;
   logic             tlb_rw;
   logic             tlb_rr;
   logic             tlb_unc;
   logic [VPN_W-1:0] tlb_ppn;

   logic tlb_miss;
   logic perm_denied;

   // Direct mapped, set index is the low vpn bits
   assign tlb_raddr = vpn[TLB_SETS_LOG2-1:0];

   // Request capture, lines up with the RAM read register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vpn_r    <= '0;
         we_r     <= 1'b0;
         root_r   <= 1'b0;
         mmu_en_r <= 1'b0;
      end else if (re) begin
         vpn_r    <= vpn;
         we_r     <= we;
         root_r   <= mode_root;
         mmu_en_r <= mmu_en;
      end
   end

   // Low half: valid and tag
   assign tlb_v   = tlb_lo[TLBL_V_BIT];
   assign tlb_tag = tlb_lo[DATA_W-1 -: VPN_W];

   // High half: rights, cache attribute, page number
   assign tlb_uw  = tlb_hi[TLBH_UW_BIT];
   assign tlb_ur  = tlb_hi[TLBH_UR_BIT];
   assign tlb_rw  = tlb_hi[TLBH_RW_BIT];
   assign tlb_rr  = tlb_hi[TLBH_RR_BIT];
   assign tlb_unc = tlb_hi[TLBH_UNC_BIT];
   assign tlb_ppn = tlb_hi[DATA_W-1 -: VPN_W];

   // Hit needs a valid entry with the full vpn as tag
   assign tlb_miss = !(tlb_v && (tlb_tag == vpn_r));

   // Root checks RR/RW, user checks UR/UW
   always_comb begin
      if (root_r) begin
         perm_denied = we_r ? !tlb_rw : !tlb_rr;
      end else begin
         perm_denied = we_r ? !tlb_uw : !tlb_ur;
      end
   end

   // Exceptions only when translation is on
   assign tlb_miss_exc   = tlb_miss && mmu_en_r;
   // A miss takes priority over a page fault
   assign page_fault_exc = perm_denied && !tlb_miss && mmu_en_r;

   // Identity mapping when translation is off
   assign ppn = mmu_en_r ? tlb_ppn : vpn_r;

   generate
      if (UNCACHED_SEG_EN != 0) begin : g_unc_seg
         // Whole segment at 0x8xxxxxxx bypasses the cache
         assign uncached = tlb_unc || (ppn[VPN_W-1 -: 4] == UNC_SEG_NIBBLE);
      end else begin : g_no_unc_seg
         assign uncached = tlb_unc;
      end
   endgenerate

endmodule

// ==== design/tlb_sdpram.sv ====
// Single-clock simple dual-port RAM for one half of the TLB
// One write port, one registered read port that only loads on re
// Optional bypass returns din on a same-address read and write

`timescale 1ns/1ps

module tlb_sdpram #(
   parameter int AW        = 4,
   parameter int DW        = 32,
   parameter int BYPASS_EN = 1
) (
   input  logic          clk,
   input  logic          arst_n,
   input  logic [AW-1:0] raddr,
   input  logic          re,
   input  logic [AW-1:0] waddr,
   input  logic          we,
   input  logic [DW-1:0] din,
   output logic [DW-1:0] dout
);

   // Storage array, no reset
   logic [DW-1:0] mem [2**AW];

   // Same address hit between the two ports this cycle
   logic bypass_hit;

   assign bypass_hit = (BYPASS_EN != 0) && we && (waddr == raddr);

   // Write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= din;
      end
   end

   // Read port
   // Output register holds its value while re is low
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dout <= '0;
      end else if (re) begin
         // New data wins on a collision
         if (bypass_hit) begin
            dout <= din;
         end else begin
            dout <= mem[raddr];
         end
      end
   end

endmodule

// ==== design/dmmu_pkg.sv ====
// Shared definitions for the data MMU and its TLB write port
// Address and word widths, TLB entry field positions, write FSM states
// Imported by wildcard in the module headers that need them

package dmmu_pkg;

   // Virtual and physical address width
   localparam int ADDR_W = 32;
   // Machine word, also one TLB half entry
   localparam int DATA_W = 32;

   // TLB half entries, write data, zero-extended page numbers
   typedef logic [DATA_W-1:0] word_t;

   // Low half of a TLB entry
   // Valid flag in bit 0, tag in the top bits
   localparam int TLBL_V_BIT = 0;

   // High half of a TLB entry
   // Page number in the top bits, attributes at the bottom
   localparam int TLBH_P_BIT   = 0;
   // User write / read rights
   localparam int TLBH_UW_BIT  = 3;
   localparam int TLBH_UR_BIT  = 4;
   // Root write / read rights
   localparam int TLBH_RW_BIT  = 5;
   localparam int TLBH_RR_BIT  = 6;
   // Page is not cacheable
   localparam int TLBH_UNC_BIT = 7;
   // Reserved for software
   localparam int TLBH_S_BIT   = 8;

   // Top nibble of a physical address in the uncached segment
   localparam logic [3:0] UNC_SEG_NIBBLE = 4'h8;

   // TLB write controller states
   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      ACK
   } tlb_wr_state_e;

endpackage
